//--- filelist.f
+incdir+hw
hw/c1BusPkg.sv
hw/c1IoPkg.sv
hw/c1AddressDecode.sv
hw/c1Wait.sv
hw/c1Inputs.sv
hw/c1Regs.sv
hw/neoC1.sv
tests/tbClock.sv
tests/neoC1_checker.sv
tests/neoC1Tb.sv

//--- hw/c1AddressDecode.sv
`default_nettype none

`include "c1_defines.svh"

module c1AddressDecode (
	input logic [`C1_ADDR_MSB:`C1_ADDR_LSB] m68kAddr,
	input logic a22z,
	input logic a23z,
	input logic nLds,
	input logic nUds,
	input logic rw,
	input logic nAs,
	output logic nRomOeL,
	output logic nRomOeU,
	output logic nPortOeL,
	output logic nPortOeU,
	output logic nPortWeL,
	output logic nPortWeU,
	output logic nPortAdrs,
	output logic nWrL,
	output logic nWrU,
	output logic nWwL,
	output logic nWwU,
	output logic nSromOeL,
	output logic nSromOeU,
	output logic nSramOeL,
	output logic nSramOeU,
	output logic nSramWeL,
	output logic nSramWeU,
	output logic nLspOe,
	output logic nLspWe,
	output logic nCrdO,
	output logic nCrdW,
	output logic nCrdC,
	output logic nDipRd0,
	output logic nDipRd1,
	output logic nBitW0,
	output logic nBitW1,
	output logic nPal,
	output c1BusPkg::zoneT zone,
	output c1BusPkg::ioSelT ioSel
);

	logic [1:0] zoneBits;
	logic [2:0] ioSub;
	logic romZone, wramZone, portZone, ioZone;
	logic cardZone, sromZone, sramZone, lspcZone;
	logic evenIo;
	logic nWordAccess;

	assign zoneBits = m68kAddr[`C1_ADDR_MSB -: 2];
	assign ioSub = m68kAddr[`C1_IOSUB_MSB:`C1_ADDR_LSB];

	always_comb begin
		zone = c1BusPkg::zoneNone;
		case ({a23z, a22z})
			2'b00: begin
				case (zoneBits)
					2'b00: zone = c1BusPkg::zoneRom;
					2'b01: zone = c1BusPkg::zoneWram;
					2'b10: zone = c1BusPkg::zonePort;
					default: zone = c1BusPkg::zoneIo;
				endcase
			end
			2'b01: zone = c1BusPkg::zonePal;
			2'b10: zone = c1BusPkg::zoneCard;
			default: begin
				if (zoneBits == 2'b00)
					zone = c1BusPkg::zoneSrom;
				else if (zoneBits == 2'b01)
					zone = c1BusPkg::zoneSram;
			end
		endcase
	end

	assign romZone = (zone == c1BusPkg::zoneRom);
	assign wramZone = (zone == c1BusPkg::zoneWram);
	assign portZone = (zone == c1BusPkg::zonePort);
	assign ioZone = (zone == c1BusPkg::zoneIo);
	assign cardZone = (zone == c1BusPkg::zoneCard);
	assign sromZone = (zone == c1BusPkg::zoneSrom);
	assign sramZone = (zone == c1BusPkg::zoneSram);
	assign lspcZone = ioZone & (ioSub == 3'b110);	// 3C0000-3DFFFF

	// Even io bytes are the C1 registers themselves
	assign evenIo = ioZone & ~nUds;
	assign ioSel.ctrl1 = evenIo & (ioSub == 3'b000);
	assign ioSel.icom = evenIo & (ioSub == 3'b001);
	assign ioSel.ctrl2 = evenIo & (ioSub == 3'b010);
	assign ioSel.statusB = evenIo & (ioSub == 3'b100);

	// Odd io bytes go out to the DIP switches and the bit latches
	assign nDipRd0 = nLds | ~rw | ~ioZone | (ioSub != 3'b000);
	assign nDipRd1 = nLds | ~rw | ~ioZone | (ioSub != 3'b001);
	assign nBitW0 = nLds | rw | ~ioZone | (ioSub != 3'b100);
	assign nBitW1 = nLds | rw | ~ioZone | (ioSub != 3'b101);

	assign nPal = a23z | ~a22z;	// Palette RAM is decoded from address alone
	assign nWordAccess = nLds | nUds;

	assign nRomOeL = ~rw | nLds | ~romZone | nAs;
	assign nRomOeU = ~rw | nUds | ~romZone | nAs;
	assign nPortOeL = ~rw | nLds | ~portZone | nAs;
	assign nPortOeU = ~rw | nUds | ~portZone | nAs;
	assign nPortWeL = rw | nLds | ~portZone | nAs;
	assign nPortWeU = rw | nUds | ~portZone | nAs;
	assign nPortAdrs = ~portZone | nAs;	// Address latch for the cartridge port
	assign nWrL = ~rw | nLds | ~wramZone | nAs;
	assign nWrU = ~rw | nUds | ~wramZone | nAs;
	assign nWwL = rw | nLds | ~wramZone | nAs;
	assign nWwU = rw | nUds | ~wramZone | nAs;
	assign nSromOeL = ~rw | nLds | ~sromZone | nAs;
	assign nSromOeU = ~rw | nUds | ~sromZone | nAs;
	assign nSramOeL = ~rw | nLds | ~sramZone | nAs;
	assign nSramOeU = ~rw | nUds | ~sramZone | nAs;
	assign nSramWeL = rw | nLds | ~sramZone | nAs;
	assign nSramWeU = rw | nUds | ~sramZone | nAs;

	// LSPC and memory card only take word accesses
	assign nLspOe = ~rw | nWordAccess | ~lspcZone | nAs;
	assign nLspWe = rw | nWordAccess | ~lspcZone | nAs;
	assign nCrdO = ~rw | nWordAccess | ~cardZone | nAs;
	assign nCrdW = rw | nWordAccess | ~cardZone | nAs;
	assign nCrdC = nCrdO & nCrdW;	// Card chip enable

endmodule

`default_nettype wire

//--- hw/c1BusPkg.sv
`default_nettype none

package c1BusPkg;

	// Memory map zones of the 68000 bus
	typedef enum logic [3:0] {
		zoneRom,	// 000000-0FFFFF
		zoneWram,	// 100000-1FFFFF
		zonePort,	// 200000-2FFFFF
		zoneIo,	// 300000-3FFFFF
		zonePal,	// 400000-7FFFFF
		zoneCard,	// 800000-BFFFFF
		zoneSrom,	// C00000-CFFFFF
		zoneSram,	// D00000-DFFFFF
		zoneNone
	} zoneT;

	// Even-byte io accesses, one bit per register, active high
	typedef struct packed {
		logic ctrl1;	// 300000
		logic icom;	// 320000
		logic ctrl2;	// 340000
		logic statusB;	// 380000
	} ioSelT;

endpackage

`default_nettype wire

//--- hw/c1Inputs.sv
`default_nettype none

module c1Inputs (
	input c1BusPkg::ioSelT ioSel,
	input logic rw,
	input logic [9:0] p1In,
	input logic [9:0] p2In,
	input logic nCd1,
	input logic nCd2,
	input logic nWp,
	input logic systemMode,
	input logic [7:0] replyData,
	output logic [7:0] m68kDataOut,
	output logic m68kDataOe
);

	c1IoPkg::statusBT statusByte;

	assign statusByte.systemMode = systemMode;
	assign statusByte.nWp = nWp;
	assign statusByte.nCd2 = nCd2;
	assign statusByte.nCd1 = nCd1;
	assign statusByte.p2Hi = p2In[9:8];
	assign statusByte.p1Hi = p1In[9:8];

	always_comb begin
		m68kDataOut = 8'h00;
		m68kDataOe = 1'b0;
		if (rw) begin
			m68kDataOe = 1'b1;
			if (ioSel.ctrl1)
				m68kDataOut = p1In[7:0];
			else if (ioSel.ctrl2)
				m68kDataOut = p2In[7:0];
			else if (ioSel.statusB)
				m68kDataOut = statusByte;
			else if (ioSel.icom)
				m68kDataOut = replyData;	// Z80 reply
			else
				m68kDataOe = 1'b0;	// Not ours, leave the bus alone
		end
	end

endmodule

`default_nettype wire

//--- hw/c1IoPkg.sv
`default_nettype none

package c1IoPkg;

	// Upper data byte returned by a statusB read, msb first
	typedef struct packed {
		logic systemMode;	// High on MVS
		logic nWp;	// Card write protect
		logic nCd2;	// Card detect pins
		logic nCd1;
		logic [1:0] p2Hi;	// Player 2 bits 9 and 8
		logic [1:0] p1Hi;	// Player 1 bits 9 and 8
	} statusBT;

endpackage

`default_nettype wire

//--- hw/c1Regs.sv
`default_nettype none

module c1Regs (
	input logic clk68kClk,
	input logic reset,
	input c1BusPkg::ioSelT ioSel,
	input logic rw,
	input logic [15:8] m68kDataIn,
	input logic [7:0] sddIn,
	input logic nSdz80R,
	input logic nSdz80W,
	input logic nSdz80Clr,
	output logic [7:0] replyData,
	output logic [7:0] sddOut,
	output logic sddOe,
	output logic nSdw
);

	logic [7:0] command;
	logic cmdWrite;
	logic cmdWriteD;
	logic captured;	// Command taken on the last edge
	logic nSdz80WD;

	assign cmdWrite = ioSel.icom & ~rw;

	// Control state
	always_ff @(posedge clk68kClk) begin
		if (reset) begin
			cmdWriteD <= 1'b0;
			captured <= 1'b0;
			nSdw <= 1'b1;
			nSdz80WD <= 1'b1;
		end else begin
			cmdWriteD <= cmdWrite;
			captured <= cmdWrite & ~cmdWriteD;
			nSdw <= ~captured;	// One-cycle NMI request to the Z80
			nSdz80WD <= nSdz80W;
		end
	end

	// Sound command from the 68000, cleared by the Z80
	always_ff @(posedge clk68kClk) begin
		if (cmdWrite && !cmdWriteD)
			command <= m68kDataIn;
		else if (!nSdz80Clr)
			command <= 8'h00;
	end

	// Reply byte, taken on the falling edge of the Z80 write
	always_ff @(posedge clk68kClk) begin
		if (!nSdz80W && nSdz80WD)
			replyData <= sddIn;
	end

	assign sddOe = ~nSdz80R;
	assign sddOut = nSdz80R ? 8'h00 : command;

endmodule

`default_nettype wire

//--- hw/c1Wait.sv
`default_nettype none

`include "c1_defines.svh"

module c1Wait (
	input logic clk68kClk,
	input logic reset,
	input logic nAs,
	input c1BusPkg::zoneT zone,
	input logic nRomWait,
	input logic nPWait0,
	input logic nPWait1,
	input logic pdtack,
	output logic nDtack
);

	localparam int waitW = `C1_WAIT_W;

	logic [waitW-1:0] loadCnt;
	logic [waitW-1:0] waitCnt;
	logic busy;	// Bus cycle already started
	logic isCard;
	logic cardAck;	// pdtack seen on the previous edge

	// Wait edges beyond the first, per zone
	always_comb begin
		case (zone)
			c1BusPkg::zoneRom:
				loadCnt = nRomWait ? '0 : waitW'(`C1_ZONE_ROM_WAIT);
			c1BusPkg::zonePort:
				loadCnt = waitW'({~nPWait1, ~nPWait0} * `C1_PORT_WAIT_BASE);
			c1BusPkg::zoneCard:
				loadCnt = waitW'(`C1_CARD_TIMEOUT - 1);	// Timeout only
			default:
				loadCnt = '0;
		endcase
	end

	always_ff @(posedge clk68kClk) begin
		if (reset) begin
			busy <= 1'b0;
			waitCnt <= '0;
			isCard <= 1'b0;
			cardAck <= 1'b0;
			nDtack <= 1'b1;
		end else if (nAs) begin
			busy <= 1'b0;
			cardAck <= 1'b0;
			nDtack <= 1'b1;
		end else if (!busy) begin
			// First edge with nAs low
			busy <= 1'b1;
			waitCnt <= loadCnt;
			isCard <= (zone == c1BusPkg::zoneCard);
			cardAck <= (zone == c1BusPkg::zoneCard) & pdtack;
		end else if (nDtack) begin
			if (waitCnt == '0 || cardAck) begin
				nDtack <= 1'b0;
			end else begin
				waitCnt <= waitCnt - 1'b1;
				cardAck <= isCard & pdtack;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/c1_defines.svh
`ifndef C1_DEFINES_SVH
`define C1_DEFINES_SVH

// 68000 address bits seen by the C1
`define C1_ADDR_MSB 21
`define C1_ADDR_LSB 17
`define C1_IOSUB_MSB 19	// Top bit of the io sub-zone field

// Wait states, in 68000 clock edges
`define C1_ZONE_ROM_WAIT 1	// Extra edge when nRomWait is low
`define C1_PORT_WAIT_BASE 1	// Per step of the inverted nPWait code

// Card zone gives up on pdtack after this many edges
`define C1_CARD_TIMEOUT 8

// Width of the wait down-counter, must hold C1_CARD_TIMEOUT - 1
`define C1_WAIT_W 4

`endif

//--- hw/neoC1.sv
`default_nettype none

`include "c1_defines.svh"

module neoC1 (
	input logic clk68kClk,
	input logic reset,
	input logic [`C1_ADDR_MSB:`C1_ADDR_LSB] m68kAddr,
	input logic a22z,
	input logic a23z,
	input logic nLds,
	input logic nUds,
	input logic rw,
	input logic nAs,
	input logic [15:8] m68kDataIn,
	input logic [9:0] p1In,
	input logic [9:0] p2In,
	input logic nCd1,
	input logic nCd2,
	input logic nWp,
	input logic nRomWait,
	input logic nPWait0,
	input logic nPWait1,
	input logic pdtack,
	input logic [7:0] sddIn,
	input logic nSdz80R,
	input logic nSdz80W,
	input logic nSdz80Clr,
	input logic systemMode,
	output logic nRomOeL,
	output logic nRomOeU,
	output logic nPortOeL,
	output logic nPortOeU,
	output logic nPortWeL,
	output logic nPortWeU,
	output logic nPortAdrs,
	output logic nWrL,
	output logic nWrU,
	output logic nWwL,
	output logic nWwU,
	output logic nSromOeL,
	output logic nSromOeU,
	output logic nSramOeL,
	output logic nSramOeU,
	output logic nSramWeL,
	output logic nSramWeU,
	output logic nLspOe,
	output logic nLspWe,
	output logic nCrdO,
	output logic nCrdW,
	output logic nCrdC,
	output logic nDipRd0,
	output logic nDipRd1,
	output logic nBitW0,
	output logic nBitW1,
	output logic nPal,
	output logic [15:8] m68kDataOut,
	output logic m68kDataOe,
	output logic [7:0] sddOut,
	output logic sddOe,
	output logic nSdw,
	output logic nDtack
);

	c1BusPkg::zoneT zone;
	c1BusPkg::ioSelT ioSel;
	logic [7:0] replyData;

	c1AddressDecode u_addressDecode (
		.m68kAddr(m68kAddr), .a22z(a22z), .a23z(a23z),
		.nLds(nLds), .nUds(nUds), .rw(rw), .nAs(nAs),
		.nRomOeL(nRomOeL), .nRomOeU(nRomOeU),
		.nPortOeL(nPortOeL), .nPortOeU(nPortOeU),
		.nPortWeL(nPortWeL), .nPortWeU(nPortWeU), .nPortAdrs(nPortAdrs),
		.nWrL(nWrL), .nWrU(nWrU), .nWwL(nWwL), .nWwU(nWwU),
		.nSromOeL(nSromOeL), .nSromOeU(nSromOeU),
		.nSramOeL(nSramOeL), .nSramOeU(nSramOeU),
		.nSramWeL(nSramWeL), .nSramWeU(nSramWeU),
		.nLspOe(nLspOe), .nLspWe(nLspWe),
		.nCrdO(nCrdO), .nCrdW(nCrdW), .nCrdC(nCrdC),
		.nDipRd0(nDipRd0), .nDipRd1(nDipRd1),
		.nBitW0(nBitW0), .nBitW1(nBitW1), .nPal(nPal),
		.zone(zone), .ioSel(ioSel)
	);

	c1Wait u_wait (
		.clk68kClk(clk68kClk), .reset(reset), .nAs(nAs), .zone(zone),
		.nRomWait(nRomWait), .nPWait0(nPWait0), .nPWait1(nPWait1),
		.pdtack(pdtack), .nDtack(nDtack)
	);

	c1Inputs u_inputs (
		.ioSel(ioSel), .rw(rw), .p1In(p1In), .p2In(p2In),
		.nCd1(nCd1), .nCd2(nCd2), .nWp(nWp), .systemMode(systemMode),
		.replyData(replyData),
		.m68kDataOut(m68kDataOut), .m68kDataOe(m68kDataOe)
	);

	c1Regs u_regs (
		.clk68kClk(clk68kClk), .reset(reset), .ioSel(ioSel), .rw(rw),
		.m68kDataIn(m68kDataIn), .sddIn(sddIn),
		.nSdz80R(nSdz80R), .nSdz80W(nSdz80W), .nSdz80Clr(nSdz80Clr),
		.replyData(replyData), .sddOut(sddOut), .sddOe(sddOe), .nSdw(nSdw)
	);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --top-module neoC1Tb -f filelist.f -o neoC1Sim > build.log 2>&1 \
	|| { cat build.log; exit 1; }
./obj_dir/neoC1Sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -qx "test passed" sim.log && exit 0 || exit 1

//--- tests/neoC1Tb.sv
`default_nettype none

`include "c1_defines.svh"

module neoC1Tb;

	localparam int accessCount = 200;
	localparam int maxAccessCycles = 12;
	localparam int maxCycles = accessCount * maxAccessCycles + 1600;

	logic clk68kClk;
	logic reset;
	logic [`C1_ADDR_MSB:`C1_ADDR_LSB] m68kAddr;
	logic a22z;
	logic a23z;
	logic nLds;
	logic nUds;
	logic rw;
	logic nAs;
	logic [15:8] m68kDataIn;
	logic [9:0] p1In;
	logic [9:0] p2In;
	logic nCd1;
	logic nCd2;
	logic nWp;
	logic nRomWait;
	logic nPWait0;
	logic nPWait1;
	logic pdtack;
	logic [7:0] sddIn;
	logic nSdz80R;
	logic nSdz80W;
	logic nSdz80Clr;
	logic systemMode;
	logic nRomOeL, nRomOeU, nPortOeL, nPortOeU, nPortWeL, nPortWeU, nPortAdrs;
	logic nWrL, nWrU, nWwL, nWwU, nSromOeL, nSromOeU;
	logic nSramOeL, nSramOeU, nSramWeL, nSramWeU, nLspOe, nLspWe;
	logic nCrdO, nCrdW, nCrdC, nDipRd0, nDipRd1, nBitW0, nBitW1, nPal;
	logic [15:8] m68kDataOut;
	logic m68kDataOe;
	logic [7:0] sddOut;
	logic sddOe;
	logic nSdw;
	logic nDtack;

	logic [26:0] strobeVec;
	logic [8:0] expRead;
	logic [7:0] expReply = 8'h00;	// Model of the Z80 reply latch
	logic [16:0] lfsrState = 17'd79308;
	logic [31:0] r;
	logic [7:0] cmdByte;
	logic [2:0] sub;
	int errorCount = 0;
	int cycleCount = 0;
	int totalErrors;

	tbClock u_clock (.clk(clk68kClk));

	neoC1 u_neoC1 (.*);

	bind neoC1 neoC1_checker u_checker (
		.clk68kClk(clk68kClk), .reset(reset), .nAs(nAs), .nDtack(nDtack),
		.nRomOeL(nRomOeL), .nRomOeU(nRomOeU), .nWrL(nWrL), .nWrU(nWrU),
		.nPortOeL(nPortOeL), .nPortOeU(nPortOeU),
		.nSromOeL(nSromOeL), .nSromOeU(nSromOeU),
		.nSramOeL(nSramOeL), .nSramOeU(nSramOeU)
	);

	assign strobeVec = {nRomOeL, nRomOeU, nPortOeL, nPortOeU, nPortWeL, nPortWeU, nPortAdrs,
		nWrL, nWrU, nWwL, nWwU, nSromOeL, nSromOeU, nSramOeL, nSramOeU, nSramWeL, nSramWeU,
		nLspOe, nLspWe, nCrdO, nCrdW, nCrdC, nDipRd0, nDipRd1, nBitW0, nBitW1, nPal};

	// 17-bit Fibonacci LFSR, taps 17 and 14
	function automatic logic [16:0] lfsrNext(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	function logic [31:0] takeBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			v = {v[30:0], lfsrState[0]};
		end
		return v;
	endfunction

	// Expected strobes, top is {a23, a22, a21..a17}
	function automatic logic [26:0] refStrobes(input logic [6:0] top, input logic nL,
		input logic nU, input logic rwIn, input logic nAsIn);
		logic rom, wram, port, io, card, srom, sram, lspc;
		logic rd, wr, lo, up, word;
		logic [2:0] s;
		logic [26:0] act;
		rom = (top[6:3] == 4'h0);
		wram = (top[6:3] == 4'h1);
		port = (top[6:3] == 4'h2);
		io = (top[6:3] == 4'h3);
		card = (top[6:5] == 2'b10);
		srom = (top[6:3] == 4'hC);
		sram = (top[6:3] == 4'hD);
		s = top[2:0];
		lspc = io & (s == 3'd6);	// 3C0000
		rd = rwIn & ~nAsIn;
		wr = ~rwIn & ~nAsIn;
		lo = ~nL;
		up = ~nU;
		word = lo & up;
		act = {rom & rd & lo, rom & rd & up,
			port & rd & lo, port & rd & up, port & wr & lo, port & wr & up, port & ~nAsIn,
			wram & rd & lo, wram & rd & up, wram & wr & lo, wram & wr & up,
			srom & rd & lo, srom & rd & up,
			sram & rd & lo, sram & rd & up, sram & wr & lo, sram & wr & up,
			lspc & rd & word, lspc & wr & word,
			card & rd & word, card & wr & word, card & ~nAsIn & word,
			io & lo & rwIn & (s == 3'd0), io & lo & rwIn & (s == 3'd1),	// DIP reads
			io & lo & ~rwIn & (s == 3'd4), io & lo & ~rwIn & (s == 3'd5),
			~top[6] & top[5]};	// Palette 400000-7FFFFF
		return ~act;
	endfunction

	// {enable, byte} seen on the upper data byte
	function automatic logic [8:0] refRead(input logic [6:0] top, input logic nU,
		input logic rdIn, input logic [9:0] p1, input logic [9:0] p2, input logic cd1,
		input logic cd2, input logic wp, input logic sys, input logic [7:0] reply);
		c1IoPkg::statusBT st;
		logic [8:0] res;
		st.systemMode = sys;
		st.nWp = wp;
		st.nCd2 = cd2;
		st.nCd1 = cd1;
		st.p2Hi = p2[9:8];
		st.p1Hi = p1[9:8];
		res = 9'h000;
		if (top[6:3] == 4'h3 && !nU && rdIn) begin
			case (top[2:0])
				3'd0: res = {1'b1, p1[7:0]};
				3'd1: res = {1'b1, reply};
				3'd2: res = {1'b1, p2[7:0]};
				3'd4: res = {1'b1, st};
				default: res = 9'h000;
			endcase
		end
		return res;
	endfunction

	// Edges from the nAs sample edge to nDtack low
	function automatic int refWaitEdges(input logic [6:0] top, input logic romWait,
		input logic [1:0] pWait);
		logic [1:0] code;
		int edges;
		code = ~pWait;
		edges = 1;
		if (top[6:3] == 4'h0 && !romWait)
			edges = 1 + `C1_ZONE_ROM_WAIT;
		else if (top[6:3] == 4'h2)
			edges = 1 + int'(code) * `C1_PORT_WAIT_BASE;
		else if (top[6:5] == 2'b10)
			edges = `C1_CARD_TIMEOUT;	// No pdtack
		return edges;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			errorCount++;
		end
	endtask

	task automatic setBus(input logic [6:0] top, input logic rwIn, input logic nL,
		input logic nU, input logic nA);
		{a23z, a22z, m68kAddr} <= top;
		rw <= rwIn;
		nLds <= nL;
		nUds <= nU;
		nAs <= nA;
	endtask

	task automatic z80Write(input logic [7:0] b);
		@(posedge clk68kClk);
		sddIn <= b;
		nSdz80W <= 1'b0;
		@(posedge clk68kClk);	// Falling edge seen here
		expReply = b;
		nSdz80W <= 1'b1;
	endtask

	task automatic z80ReadCheck(input logic [7:0] exp);
		@(posedge clk68kClk);
		nSdz80R <= 1'b0;
		@(negedge clk68kClk);
		checkValue("sddOe", 32'(sddOe), 32'd1);
		checkValue("sddOut", 32'(sddOut), 32'(exp));
		@(posedge clk68kClk);
		nSdz80R <= 1'b1;
		@(negedge clk68kClk);
		checkValue("sddOe", 32'(sddOe), 32'd0);
	endtask

	// icom write, then watch nSdw for six edges
	task automatic cpuCommandWrite(input logic [7:0] b);
		int lowCount;
		int firstLow;
		int e;
		lowCount = 0;
		firstLow = 0;
		@(posedge clk68kClk);
		setBus(7'b0011_001, 1'b0, 1'b1, 1'b0, 1'b0);
		m68kDataIn <= b;
		for (e = 1; e <= 6; e++) begin
			@(posedge clk68kClk);
			if (e == 3)
				setBus(7'h7F, 1'b1, 1'b1, 1'b1, 1'b1);
			@(negedge clk68kClk);
			if (!nSdw) begin
				lowCount++;
				if (firstLow == 0)
					firstLow = e;
			end
		end
		checkValue("nSdw low cycles", lowCount, 1);
		checkValue("nSdw pulse edge", firstLow, 2);	// Capture edge plus one
	endtask

	task automatic checkWait(input logic [6:0] top, input logic romWait,
		input logic [1:0] pWait, input int pdtackAt, input int expEdges);
		int edges;
		edges = 0;
		@(posedge clk68kClk);
		nRomWait <= romWait;
		{nPWait1, nPWait0} <= pWait;
		setBus(top, 1'b1, 1'b0, 1'b0, 1'b0);
		if (pdtackAt == 0)
			pdtack <= 1'b1;
		do begin
			@(posedge clk68kClk);
			edges++;
			if (edges == pdtackAt)
				pdtack <= 1'b1;
			@(negedge clk68kClk);
		end while (nDtack && edges < 20);
		if (nDtack) begin
			$display("nDtack never went low for a read at address top %h", top);
			errorCount++;
		end else begin
			checkValue("nDtack wait edges", edges - 1, expEdges);
		end
		@(posedge clk68kClk);
		setBus(7'h7F, 1'b1, 1'b1, 1'b1, 1'b1);
		pdtack <= 1'b0;
		@(posedge clk68kClk);
		@(negedge clk68kClk);
		checkValue("nDtack", 32'(nDtack), 32'd1);
	endtask

	// Combinational outputs against the reference on every falling edge
	always @(negedge clk68kClk) begin
		if (!reset) begin
			expRead = refRead({a23z, a22z, m68kAddr}, nUds, rw, p1In, p2In,
				nCd1, nCd2, nWp, systemMode, expReply);
			checkValue("decoder strobes", 32'(strobeVec),
				32'(refStrobes({a23z, a22z, m68kAddr}, nLds, nUds, rw, nAs)));
			checkValue("m68kDataOe", 32'(m68kDataOe), 32'(expRead[8]));
			checkValue("m68kDataOut", 32'(m68kDataOut), 32'(expRead[7:0]));
		end
	end

	always @(posedge clk68kClk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= maxCycles) begin
			$display("Timeout, the run did not finish within %0d cycles", maxCycles);
			$display("errors: %0d", errorCount);
			$display("test failed");
			$finish;
		end
	end

	initial begin
		reset <= 1'b1;
		setBus(7'h7F, 1'b1, 1'b1, 1'b1, 1'b1);	// Unmapped, bus idle
		m68kDataIn <= 8'h00;
		p1In <= 10'h000;
		p2In <= 10'h000;
		nCd1 <= 1'b1;
		nCd2 <= 1'b1;
		nWp <= 1'b1;
		systemMode <= 1'b0;
		nRomWait <= 1'b1;
		nPWait0 <= 1'b1;
		nPWait1 <= 1'b1;
		pdtack <= 1'b0;
		sddIn <= 8'h00;
		nSdz80R <= 1'b1;
		nSdz80W <= 1'b1;
		nSdz80Clr <= 1'b1;
		repeat (2) @(posedge clk68kClk);
		reset <= 1'b0;

		// Reply latch has no reset
		r = takeBits(8);
		z80Write(r[7:0]);

		repeat (120) begin
			r = takeBits(11);
			@(posedge clk68kClk);
			setBus(r[6:0], r[7], r[8], r[9], r[10]);
		end

		// Player and status reads
		repeat (30) begin
			r = takeBits(27);
			sub = (r[1:0] == 2'd0) ? 3'd0 : (r[1:0] == 2'd1) ? 3'd2 : 3'd4;
			@(posedge clk68kClk);
			p1In <= r[11:2];
			p2In <= r[21:12];
			nCd1 <= r[22];
			nCd2 <= r[23];
			nWp <= r[24];
			systemMode <= r[25];
			setBus({4'h3, sub}, 1'b1, r[26], 1'b0, 1'b0);
			@(negedge clk68kClk);
			checkValue("m68kDataOe", 32'(m68kDataOe), 32'd1);
		end
		@(posedge clk68kClk);
		setBus(7'h00, 1'b1, 1'b0, 1'b0, 1'b0);	// ROM read
		@(negedge clk68kClk);
		checkValue("m68kDataOe", 32'(m68kDataOe), 32'd0);
		@(posedge clk68kClk);
		setBus(7'b0011_000, 1'b1, 1'b0, 1'b1, 1'b0);	// Odd byte, DIP switches
		@(negedge clk68kClk);
		checkValue("m68kDataOe", 32'(m68kDataOe), 32'd0);
		@(posedge clk68kClk);
		setBus(7'h7F, 1'b1, 1'b1, 1'b1, 1'b1);
		repeat (2) @(posedge clk68kClk);

		// Sound command to the Z80, never zero so the clear shows
		r = takeBits(8);
		cmdByte = r[7:0] | 8'h01;
		cpuCommandWrite(cmdByte);
		z80ReadCheck(cmdByte);

		// Reply back to the 68000, always differs from the last one
		r = takeBits(8);
		z80Write(expReply ^ (r[7:0] | 8'h01));
		@(posedge clk68kClk);
		setBus(7'b0011_001, 1'b1, 1'b1, 1'b0, 1'b0);
		@(negedge clk68kClk);
		checkValue("m68kDataOut", 32'(m68kDataOut), 32'(expReply));
		@(posedge clk68kClk);
		setBus(7'h7F, 1'b1, 1'b1, 1'b1, 1'b1);
		nSdz80Clr <= 1'b0;
		@(posedge clk68kClk);
		nSdz80Clr <= 1'b1;
		z80ReadCheck(8'h00);

		// Wait states per zone
		for (int w = 0; w < 2; w++)
			checkWait(7'h00, w[0], 2'b11, -1, refWaitEdges(7'h00, w[0], 2'b11));
		for (int w = 0; w < 4; w++)
			checkWait(7'h10, 1'b1, w[1:0], -1, refWaitEdges(7'h10, 1'b1, w[1:0]));
		checkWait(7'h08, 1'b0, 2'b00, -1, refWaitEdges(7'h08, 1'b0, 2'b00));
		checkWait(7'h20, 1'b1, 2'b11, -1, refWaitEdges(7'h20, 1'b1, 2'b11));
		checkWait(7'h40, 1'b1, 2'b11, -1, refWaitEdges(7'h40, 1'b1, 2'b11));
		checkWait(7'h40, 1'b1, 2'b11, 0, 1);	// Low one edge after pdtack is seen
		checkWait(7'h40, 1'b1, 2'b11, 2, 3);

		totalErrors = errorCount + u_neoC1.u_checker.failCount;
		$display("errors: %0d checks, %0d assertions", errorCount,
			u_neoC1.u_checker.failCount);
		if (totalErrors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/neoC1_checker.sv
`default_nettype none

module neoC1_checker (
	input logic clk68kClk,
	input logic reset,
	input logic nAs,
	input logic nDtack,
	input logic nRomOeL,
	input logic nRomOeU,
	input logic nWrL,
	input logic nWrU,
	input logic nPortOeL,
	input logic nPortOeU,
	input logic nSromOeL,
	input logic nSromOeU,
	input logic nSramOeL,
	input logic nSramOeU
);

	logic [4:0] oeActive;	// One bit per memory, high while it drives the bus
	int failCount = 0;

	assign oeActive = {
		~(nRomOeL & nRomOeU),
		~(nWrL & nWrU),
		~(nPortOeL & nPortOeU),
		~(nSromOeL & nSromOeU),
		~(nSramOeL & nSramOeU)
	};

	// Bus cycle end releases DTACK one edge later
	dtackRelease: assert property (@(posedge clk68kClk) disable iff (reset) nAs |=> nDtack)
		else begin
			$error("nDtack still low on the edge after nAs was seen high");
			failCount++;
		end

	oeExclusive: assert property (@(posedge clk68kClk) disable iff (reset)
		$countones(oeActive) <= 1)
		else begin
			$error("more than one memory output enable low at once: %b", oeActive);
			failCount++;
		end

endmodule

`default_nettype wire

//--- tests/tbClock.sv
`default_nettype none

// Free-running 68000 clock, 10 time units per period
module tbClock (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

endmodule

`default_nettype wire
